// File: vlog.f
src/axi_bus_pkg.sv
src/axi_lite_master.sv
src/axi_lite_sram.sv
src/mem_subsys_top.sv
sim/tb_mem_subsys.sv

// File: run.sh
#!/bin/sh
# build and run tb_mem_subsys with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_mem_subsys -f vlog.f -o tb_mem_subsys || exit 1
out=$(./obj_dir/tb_mem_subsys)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TESTS PASSED" && echo "simulation ok" || { echo "simulation not ok"; exit 1; }

// File: sim/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;

    import axi_bus_pkg::*;

    localparam int MEM_DEPTH      = 64;
    localparam int IDX_W          = $clog2(MEM_DEPTH);
    localparam int N_RAND         = 4;
    localparam int N_OPS          = 13 + 2 * N_RAND;
    localparam int TIMEOUT_CYCLES = N_OPS * 16;
    // cycles from the driving edge to done, nothing competing
    localparam int RD_LATENCY     = 3;
    localparam int WR_LATENCY     = 4;

    typedef enum logic [1:0] {
        OP_WR,
        OP_RD,
        OP_WR_RD
    } op_kind_e;

    typedef struct packed {
        op_kind_e              kind;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        cpu_rrsp_t             exp_rsp;
        logic                  exp_err;
    } op_t;

    logic      aclk = 1'b0;
    logic      areset_n;
    logic      cpu_w_valid;
    cpu_wreq_t cpu_w_req;
    logic      cpu_w_done;
    logic      cpu_w_err;
    logic      cpu_r_valid;
    cpu_rreq_t cpu_r_req;
    logic      cpu_r_done;
    cpu_rrsp_t cpu_r_rsp;

    op_t                   ops [N_OPS];
    int                    n_ops = 0;
    logic [DATA_WIDTH-1:0] model [MEM_DEPTH];
    logic [ADDR_WIDTH-1:0] rand_addr [N_RAND];
    logic [31:0]           lcg_state = 32'h9bf4;
    int                    pass_cnt = 0;
    int                    fail_cnt = 0;
    int                    cycle_cnt = 0;

    always #4 aclk = ~aclk;

    mem_subsys_top #(
        .MEM_DEPTH (MEM_DEPTH)
    ) DUT (
        .aclk          (aclk),
        .areset_n      (areset_n),
        .cpu_w_valid_i (cpu_w_valid),
        .cpu_w_req_i   (cpu_w_req),
        .cpu_w_done_o  (cpu_w_done),
        .cpu_w_err_o   (cpu_w_err),
        .cpu_r_valid_i (cpu_r_valid),
        .cpu_r_req_i   (cpu_r_req),
        .cpu_r_done_o  (cpu_r_done),
        .cpu_r_rsp_o   (cpu_r_rsp)
    );

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("timeout waiting for done after %0d cycles", cycle_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected values follow the slave rules, write part before read part
    function automatic void add_op(op_kind_e kind, logic [31:0] addr, logic [31:0] data,
                                   logic [3:0] strb);
        logic [31:0] idx;
        op_t         op;
        idx        = addr >> 2;
        op.kind    = kind;
        op.addr    = addr;
        op.data    = data;
        op.strb    = strb;
        op.exp_err = 1'b0;
        op.exp_rsp = '0;
        if (kind != OP_RD) begin
            if (idx < 32'(MEM_DEPTH)) begin
                for (int i = 0; i < STRB_WIDTH; i++) begin
                    if (strb[i]) begin
                        model[idx[IDX_W-1:0]][8*i +: 8] = data[8*i +: 8];
                    end
                end
            end else begin
                op.exp_err = 1'b1;
            end
        end
        if (kind != OP_WR) begin
            if (idx < 32'(MEM_DEPTH)) begin
                op.exp_rsp = '{data: model[idx[IDX_W-1:0]], err: 1'b0};
            end else begin
                op.exp_rsp = '{data: '0, err: 1'b1};
            end
        end
        ops[n_ops] = op;
        n_ops++;
    endfunction

    function automatic void build_table();
        logic [31:0] rnd;
        add_op(OP_WR,    32'h0000_0000, 32'h1122_3344, 4'hf);
        add_op(OP_RD,    32'h0000_0000, 32'h0,         4'h0);
        add_op(OP_WR,    32'h0000_0004, 32'ha5a5_a5a5, 4'hf);
        // partial strobes merge into the old word
        add_op(OP_WR,    32'h0000_0000, 32'haabb_ccdd, 4'b0101);
        add_op(OP_RD,    32'h0000_0000, 32'h0,         4'h0);
        add_op(OP_WR,    32'h0000_0000, 32'h9988_7766, 4'b1000);
        add_op(OP_RD,    32'h0000_0000, 32'h0,         4'h0);
        // first index past the end, then a far one
        add_op(OP_WR,    32'h0000_0100, 32'hdead_beef, 4'hf);
        add_op(OP_RD,    32'h0000_0100, 32'h0,         4'h0);
        add_op(OP_WR,    32'h8000_0000, 32'h0bad_0bad, 4'hf);
        add_op(OP_RD,    32'h0000_0004, 32'h0,         4'h0);
        add_op(OP_WR_RD, 32'h0000_0010, 32'hcafe_f00d, 4'hf);
        add_op(OP_RD,    32'h0000_0000, 32'h0,         4'h0);
        // random words kept in the upper half
        for (int i = 0; i < N_RAND; i++) begin
            rnd          = next_rand();
            rand_addr[i] = (32'(MEM_DEPTH / 2) + (rnd >> 8) % 32'(MEM_DEPTH / 2)) << 2;
            add_op(OP_WR, rand_addr[i], next_rand(), 4'hf);
        end
        for (int i = 0; i < N_RAND; i++) begin
            add_op(OP_RD, rand_addr[i], 32'h0, 4'h0);
        end
    endfunction

    task automatic check_rsp(input int idx, input cpu_rrsp_t got, input cpu_rrsp_t exp);
        if (got !== exp) begin
            $display("error op %0d cpu_r_rsp_o got 0x%h expected 0x%h", idx, got, exp);
            fail_cnt++;
        end else begin
            $display("op %0d cpu_r_rsp_o 0x%h ok", idx, got);
            pass_cnt++;
        end
    endtask

    task automatic check_err(input int idx, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error op %0d cpu_w_err_o got 0x%h expected 0x%h", idx, got, exp);
            fail_cnt++;
        end else begin
            $display("op %0d cpu_w_err_o 0x%h ok", idx, got);
            pass_cnt++;
        end
    endtask

    task automatic check_latency(input int idx, input string name, input int got,
                                 input int exp);
        if (got != exp) begin
            $display("error op %0d %s latency got 0x%0h expected 0x%0h", idx, name, got, exp);
            fail_cnt++;
        end else begin
            $display("op %0d %s latency %0d ok", idx, name, got);
            pass_cnt++;
        end
    endtask

    task automatic run_op(input int idx);
        op_t       op;
        logic      want_w;
        logic      want_r;
        logic      w_seen;
        logic      r_seen;
        logic      got_err;
        cpu_rrsp_t got_rsp;
        int        lat;
        int        w_lat;
        int        r_lat;
        op      = ops[idx];
        want_w  = (op.kind != OP_RD);
        want_r  = (op.kind != OP_WR);
        w_seen  = !want_w;
        r_seen  = !want_r;
        got_err = 1'b0;
        got_rsp = '0;
        lat     = 0;
        w_lat   = 0;
        r_lat   = 0;
        @(posedge aclk);
        if (want_w) begin
            cpu_w_req   <= '{addr: op.addr, data: op.data, strb: op.strb};
            cpu_w_valid <= 1'b1;
        end
        if (want_r) begin
            cpu_r_req   <= '{addr: op.addr};
            cpu_r_valid <= 1'b1;
        end
        // sample mid cycle, drop each valid on the edge after its done
        while (!(w_seen && r_seen)) begin
            @(negedge aclk);
            lat++;
            if (!w_seen && cpu_w_done) begin
                w_seen  = 1'b1;
                got_err = cpu_w_err;
                w_lat   = lat;
            end
            if (!r_seen && cpu_r_done) begin
                r_seen  = 1'b1;
                got_rsp = cpu_r_rsp;
                r_lat   = lat;
            end
            @(posedge aclk);
            if (want_w && w_seen) begin
                cpu_w_valid <= 1'b0;
            end
            if (want_r && r_seen) begin
                cpu_r_valid <= 1'b0;
            end
        end
        if (want_w) begin
            check_err(idx, got_err, op.exp_err);
        end
        if (want_r) begin
            check_rsp(idx, got_rsp, op.exp_rsp);
        end
        if (op.kind == OP_WR) begin
            check_latency(idx, "cpu_w_done_o", w_lat, WR_LATENCY);
        end
        if (op.kind == OP_RD) begin
            check_latency(idx, "cpu_r_done_o", r_lat, RD_LATENCY);
        end
        if (op.kind == OP_WR_RD && r_lat <= w_lat) begin
            $display("op %0d read finished before the write issued with it", idx);
            fail_cnt++;
        end
    endtask

    initial begin
        areset_n    = 1'b0;
        cpu_w_valid = 1'b0;
        cpu_w_req   = '0;
        cpu_r_valid = 1'b0;
        cpu_r_req   = '0;
        build_table();
        repeat (2) @(posedge aclk);
        areset_n <= 1'b1;
        for (int i = 0; i < n_ops; i++) begin
            run_op(i);
        end
        $display("%0d checks passed, %0d checks failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src/mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                   aclk,
    input  logic                   areset_n,

    input  logic                   cpu_w_valid_i,
    input  axi_bus_pkg::cpu_wreq_t cpu_w_req_i,
    output logic                   cpu_w_done_o,
    output logic                   cpu_w_err_o,

    input  logic                   cpu_r_valid_i,
    input  axi_bus_pkg::cpu_rreq_t cpu_r_req_i,
    output logic                   cpu_r_done_o,
    output axi_bus_pkg::cpu_rrsp_t cpu_r_rsp_o
);

    import axi_bus_pkg::*;

    logic    aw_valid;
    logic    aw_ready;
    axi_aw_t aw;
    logic    w_valid;
    logic    w_ready;
    axi_w_t  w;
    logic    b_valid;
    logic    b_ready;
    axi_b_t  b;
    logic    ar_valid;
    logic    ar_ready;
    axi_ar_t ar;
    logic    r_valid;
    logic    r_ready;
    axi_r_t  r;

    axi_lite_master u_master (
        .aclk          (aclk),
        .areset_n      (areset_n),
        .cpu_w_valid_i (cpu_w_valid_i),
        .cpu_w_req_i   (cpu_w_req_i),
        .cpu_w_done_o  (cpu_w_done_o),
        .cpu_w_err_o   (cpu_w_err_o),
        .cpu_r_valid_i (cpu_r_valid_i),
        .cpu_r_req_i   (cpu_r_req_i),
        .cpu_r_done_o  (cpu_r_done_o),
        .cpu_r_rsp_o   (cpu_r_rsp_o),
        .aw_valid_o    (aw_valid),
        .aw_ready_i    (aw_ready),
        .aw_o          (aw),
        .w_valid_o     (w_valid),
        .w_ready_i     (w_ready),
        .w_o           (w),
        .b_valid_i     (b_valid),
        .b_ready_o     (b_ready),
        .b_i           (b),
        .ar_valid_o    (ar_valid),
        .ar_ready_i    (ar_ready),
        .ar_o          (ar),
        .r_valid_i     (r_valid),
        .r_ready_o     (r_ready),
        .r_i           (r)
    );

    axi_lite_sram #(
        .MEM_DEPTH (MEM_DEPTH)
    ) u_sram (
        .aclk       (aclk),
        .areset_n   (areset_n),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .aw_i       (aw),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .w_i        (w),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready),
        .b_o        (b),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .ar_i       (ar),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .r_o        (r)
    );

endmodule

// File: src/axi_lite_sram.sv
`timescale 1ns/1ps

module axi_lite_sram #(
    parameter int MEM_DEPTH = 256
) (
    input  logic                 aclk,
    input  logic                 areset_n,

    input  logic                 aw_valid_i,
    output logic                 aw_ready_o,
    input  axi_bus_pkg::axi_aw_t aw_i,

    input  logic                 w_valid_i,
    output logic                 w_ready_o,
    input  axi_bus_pkg::axi_w_t  w_i,

    output logic                 b_valid_o,
    input  logic                 b_ready_i,
    output axi_bus_pkg::axi_b_t  b_o,

    input  logic                 ar_valid_i,
    output logic                 ar_ready_o,
    input  axi_bus_pkg::axi_ar_t ar_i,

    output logic                 r_valid_o,
    input  logic                 r_ready_i,
    output axi_bus_pkg::axi_r_t  r_o
);

    import axi_bus_pkg::*;

    localparam int OFFS_WIDTH = $clog2(STRB_WIDTH);
    localparam int WORD_IDX_W = ADDR_WIDTH - OFFS_WIDTH;
    localparam int IDX_WIDTH  = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];

    sram_state_e state;

    logic [WORD_IDX_W-1:0] waddr_q;
    logic [WORD_IDX_W-1:0] ar_idx;
    logic                  w_in_range;
    logic                  ar_in_range;
    axi_resp_e             bresp_q;
    axi_r_t                r_q;

    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic ar_fire;
    logic r_fire;

    // aw wins over ar when both wait in idle
    assign aw_ready_o = (state == S_IDLE);
    assign ar_ready_o = (state == S_IDLE) && !aw_valid_i;
    assign w_ready_o  = (state == S_WDATA);
    assign b_valid_o  = (state == S_BRESP);
    assign r_valid_o  = (state == S_RDATA);

    assign aw_fire = aw_valid_i & aw_ready_o;
    assign w_fire  = w_valid_i & w_ready_o;
    assign b_fire  = b_valid_o & b_ready_i;
    assign ar_fire = ar_valid_i & ar_ready_o;
    assign r_fire  = r_valid_o & r_ready_i;

    // word index, byte offset dropped
    assign ar_idx      = ar_i.addr[ADDR_WIDTH-1:OFFS_WIDTH];
    assign w_in_range  = (waddr_q < WORD_IDX_W'(MEM_DEPTH));
    assign ar_in_range = (ar_idx < WORD_IDX_W'(MEM_DEPTH));

    assign b_o = '{resp: bresp_q};
    assign r_o = r_q;

    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (aw_fire) begin
                        state <= S_WDATA;
                    end else if (ar_fire) begin
                        state <= S_RDATA;
                    end
                end
                S_WDATA: begin
                    if (w_fire) begin
                        state <= S_BRESP;
                    end
                end
                S_BRESP: begin
                    if (b_fire) begin
                        state <= S_IDLE;
                    end
                end
                S_RDATA: begin
                    if (r_fire) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // array and response payloads
    always_ff @(posedge aclk) begin
        if (aw_fire) begin
            waddr_q <= aw_i.addr[ADDR_WIDTH-1:OFFS_WIDTH];
        end
        if (w_fire) begin
            if (w_in_range) begin
                for (int i = 0; i < STRB_WIDTH; i++) begin
                    if (w_i.strb[i]) begin
                        mem[waddr_q[IDX_WIDTH-1:0]][8*i +: 8] <= w_i.data[8*i +: 8];
                    end
                end
                bresp_q <= OKAY;
            end else begin
                // out of range, memory left untouched
                bresp_q <= SLVERR;
            end
        end
        if (ar_fire) begin
            if (ar_in_range) begin
                r_q.data <= mem[ar_idx[IDX_WIDTH-1:0]];
                r_q.resp <= OKAY;
            end else begin
                r_q.data <= '0;
                r_q.resp <= SLVERR;
            end
        end
    end

endmodule

// File: src/axi_lite_master.sv
`timescale 1ns/1ps

module axi_lite_master (
    input  logic                   aclk,
    input  logic                   areset_n,

    // cpu write request
    input  logic                   cpu_w_valid_i,
    input  axi_bus_pkg::cpu_wreq_t cpu_w_req_i,
    output logic                   cpu_w_done_o,
    output logic                   cpu_w_err_o,

    // cpu read request
    input  logic                   cpu_r_valid_i,
    input  axi_bus_pkg::cpu_rreq_t cpu_r_req_i,
    output logic                   cpu_r_done_o,
    output axi_bus_pkg::cpu_rrsp_t cpu_r_rsp_o,

    // write address
    output logic                   aw_valid_o,
    input  logic                   aw_ready_i,
    output axi_bus_pkg::axi_aw_t   aw_o,

    // write data
    output logic                   w_valid_o,
    input  logic                   w_ready_i,
    output axi_bus_pkg::axi_w_t    w_o,

    // write response
    input  logic                   b_valid_i,
    output logic                   b_ready_o,
    input  axi_bus_pkg::axi_b_t    b_i,

    // read address
    output logic                   ar_valid_o,
    input  logic                   ar_ready_i,
    output axi_bus_pkg::axi_ar_t   ar_o,

    // read data
    input  logic                   r_valid_i,
    output logic                   r_ready_o,
    input  axi_bus_pkg::axi_r_t    r_i
);

    import axi_bus_pkg::*;

    w_state_e w_state;
    r_state_e r_state;

    logic aw_fire;
    logic w_fire;
    logic b_fire;
    logic ar_fire;
    logic r_fire;

    // channel controls straight from the states
    assign aw_valid_o = (w_state == W_ADDR);
    assign w_valid_o  = (w_state == W_DATA);
    assign b_ready_o  = (w_state == W_RESP);
    assign ar_valid_o = (r_state == R_ADDR);
    assign r_ready_o  = (r_state == R_DATA);

    assign aw_fire = aw_valid_o & aw_ready_i;
    assign w_fire  = w_valid_o & w_ready_i;
    assign b_fire  = b_valid_i & b_ready_o;
    assign ar_fire = ar_valid_o & ar_ready_i;
    assign r_fire  = r_valid_i & r_ready_o;

    // request is held by the cpu until done
    assign aw_o = '{addr: cpu_w_req_i.addr};
    assign w_o  = '{data: cpu_w_req_i.data, strb: cpu_w_req_i.strb};
    assign ar_o = '{addr: cpu_r_req_i.addr};

    assign cpu_w_done_o = b_fire;
    assign cpu_w_err_o  = (b_i.resp == SLVERR);

    assign cpu_r_done_o = r_fire;
    assign cpu_r_rsp_o  = '{data: r_i.data, err: (r_i.resp == SLVERR)};

    // write side
    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            w_state <= W_IDLE;
        end else begin
            case (w_state)
                W_IDLE: begin
                    if (cpu_w_valid_i) begin
                        w_state <= W_ADDR;
                    end
                end
                W_ADDR: begin
                    if (aw_fire) begin
                        w_state <= W_DATA;
                    end
                end
                W_DATA: begin
                    if (w_fire) begin
                        w_state <= W_RESP;
                    end
                end
                W_RESP: begin
                    if (b_fire) begin
                        w_state <= W_IDLE;
                    end
                end
                default: begin
                    w_state <= W_IDLE;
                end
            endcase
        end
    end

    // read side, runs alongside the write side
    always_ff @(posedge aclk) begin
        if (!areset_n) begin
            r_state <= R_IDLE;
        end else begin
            case (r_state)
                R_IDLE: begin
                    if (cpu_r_valid_i) begin
                        r_state <= R_ADDR;
                    end
                end
                R_ADDR: begin
                    if (ar_fire) begin
                        r_state <= R_DATA;
                    end
                end
                R_DATA: begin
                    if (r_fire) begin
                        r_state <= R_IDLE;
                    end
                end
                default: begin
                    r_state <= R_IDLE;
                end
            endcase
        end
    end

endmodule

// File: src/axi_bus_pkg.sv
package axi_bus_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // bridge write side, AW then W then B
    typedef enum logic [1:0] {
        W_IDLE,
        W_ADDR,
        W_DATA,
        W_RESP
    } w_state_e;

    typedef enum logic [1:0] {
        R_IDLE,
        R_ADDR,
        R_DATA
    } r_state_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WDATA,
        S_BRESP,
        S_RDATA
    } sram_state_e;

    // cpu side
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
    } cpu_wreq_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
    } cpu_rreq_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  err;
    } cpu_rrsp_t;

    // axi4-lite channel payloads
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        axi_resp_e resp;
    } axi_b_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        axi_resp_e             resp;
    } axi_r_t;

endpackage
